// File: rtl/pipe_config.svh
`ifndef PIPE_CONFIG_SVH
`define PIPE_CONFIG_SVH

// ECX is register 1 of the eight architectural registers.
`define PIPE_NREGS 8

`define PIPE_XLEN 32

// opcode, register fields and immediate of one instruction word.
`define PIPE_IW 24

// the ag, ro, ex and wb stages carry write records back to decode.
`define PIPE_NSTAGES 4

`endif

// File: rtl/pipe_pkg.sv
`include "pipe_config.svh"

package pipe_pkg;

  localparam int unsigned reg_aw = $clog2(`PIPE_NREGS);

  typedef logic [reg_aw-1:0]     reg_idx_t;
  typedef logic [`PIPE_XLEN-1:0] word_t;

  localparam reg_idx_t ecx_idx = reg_idx_t'(1);

  typedef enum logic [2:0] {
    op_nop        = 3'd0,
    op_add        = 3'd1,
    op_sub        = 3'd2,
    op_xor        = 3'd3,
    op_movi       = 3'd4,
    op_repne_scan = 3'd5,
    op_hlt        = 3'd6
  } op_e;

  typedef struct packed {
    op_e                   op;
    reg_idx_t              dst;
    reg_idx_t              src;
    logic [`PIPE_IW-10:0]  imm;
  } alu_view_t;

  typedef struct packed {
    op_e                   op;
    logic [`PIPE_IW-12:0]  rsvd;
    logic [7:0]            cmp;   // byte the scan looks for in the low byte of ECX.
  } ctrl_view_t;

  // the opcode lines up in both views, so either one can be used to pick the view.
  typedef union packed {
    alu_view_t  alu;
    ctrl_view_t ctrl;
  } insn_u;

  typedef struct packed {
    op_e      op;
    reg_idx_t dst;
    reg_idx_t src;
    word_t    imm;
    logic     wr_reg;
    logic     rd_src;
    logic     rd_dst;
    logic     wr_zf;
    logic     rep_iter;
  } uop_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t dst;
    logic     wr_reg;
    logic     wr_zf;
  } wrec_t;

  typedef struct packed {
    reg_idx_t dst;
    word_t    data;
    logic     zf;
    logic     rep_iter;
  } retire_t;

endpackage

// File: rtl/de_stage.sv
module de_stage (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            insn_valid,
  output logic            insn_ready,
  input  pipe_pkg::insn_u insn,
  input  logic            stall_de,
  input  logic            repne_stall,
  input  logic            ld_ag,
  output logic            de_valid,
  output pipe_pkg::uop_t  de_uop,
  output logic            halted
);

  pipe_pkg::insn_u de_insn;
  logic            ready_en;
  logic            consume;
  logic            take;

  // the decode register empties when ag loads and nothing holds the instruction here.
  assign consume    = de_valid & ld_ag & ~stall_de & ~repne_stall;
  assign insn_ready = ready_en & ~halted & (~de_valid | consume);
  assign take       = insn_valid & insn_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ready_en <= 1'b0;
      de_valid <= 1'b0;
      halted   <= 1'b0;
    end else begin
      ready_en <= 1'b1;   // keeps the port closed for the first cycle out of reset.
      if (take) begin
        de_valid <= 1'b1;
        if (insn.alu.op == pipe_pkg::op_hlt) begin
          halted <= 1'b1;
        end
      end else if (consume) begin
        de_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      de_insn <= insn;
    end
  end

  always_comb begin
    de_uop    = '0;
    de_uop.op = de_insn.alu.op;
    case (de_insn.alu.op)
      pipe_pkg::op_add, pipe_pkg::op_sub, pipe_pkg::op_xor: begin
        de_uop.dst    = de_insn.alu.dst;
        de_uop.src    = de_insn.alu.src;
        de_uop.imm    = pipe_pkg::word_t'(de_insn.alu.imm);
        de_uop.rd_src = 1'b1;
        de_uop.rd_dst = 1'b1;
        de_uop.wr_reg = 1'b1;
        de_uop.wr_zf  = 1'b1;
      end
      pipe_pkg::op_movi: begin
        de_uop.dst    = de_insn.alu.dst;
        de_uop.imm    = pipe_pkg::word_t'(de_insn.alu.imm);
        de_uop.wr_reg = 1'b1;
        de_uop.wr_zf  = 1'b1;
      end
      pipe_pkg::op_repne_scan: begin
        // every copy that leaves decode is one iteration on ECX.
        de_uop.dst      = pipe_pkg::ecx_idx;
        de_uop.imm      = pipe_pkg::word_t'(de_insn.ctrl.cmp);
        de_uop.rd_dst   = 1'b1;
        de_uop.wr_reg   = 1'b1;
        de_uop.wr_zf    = 1'b1;
        de_uop.rep_iter = 1'b1;
      end
      default: begin
        // nop and hlt read and write nothing.
        de_uop.dst = de_insn.alu.dst;
      end
    endcase
  end

endmodule

// File: rtl/de_dep_v_ld_logic.sv
`include "pipe_config.svh"

module de_dep_v_ld_logic (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  advance,
  input  logic                  de_valid,
  input  pipe_pkg::uop_t        de_uop,
  input  pipe_pkg::wrec_t       ag_rec,
  input  pipe_pkg::wrec_t       ro_rec,
  input  pipe_pkg::wrec_t       ex_rec,
  input  pipe_pkg::wrec_t       wb_rec,
  input  logic [`PIPE_XLEN-1:0] ecx,
  input  logic                  zf,
  output logic                  dep_stall,
  output logic                  repne_stall,
  output logic                  hlt_stall,
  output logic                  stall_de,
  output logic                  v_ag,
  output logic                  ld_ag
);

  pipe_pkg::wrec_t recs [`PIPE_NSTAGES];
  logic            is_repne;
  logic            is_hlt;
  logic            ecx_nz;
  logic            reg_hit;
  logic            zf_busy;
  logic            repne_flag;
  logic            repne_flag_in;
  logic            repne_in0;
  logic            repne_in1;
  logic            repne_stop;

  assign recs = '{ag_rec, ro_rec, ex_rec, wb_rec};

  assign is_repne = de_uop.op == pipe_pkg::op_repne_scan;
  assign is_hlt   = de_uop.op == pipe_pkg::op_hlt;
  assign ecx_nz   = |ecx;

  always_comb begin
    reg_hit = 1'b0;
    zf_busy = 1'b0;
    for (int i = 0; i < `PIPE_NSTAGES; i++) begin
      if (recs[i].valid && recs[i].wr_reg) begin
        if (de_uop.rd_src && recs[i].dst == de_uop.src) begin
          reg_hit = 1'b1;
        end
        if (de_uop.rd_dst && recs[i].dst == de_uop.dst) begin
          reg_hit = 1'b1;
        end
      end
      if (recs[i].valid && recs[i].wr_zf) begin
        zf_busy = 1'b1;
      end
    end
  end

  assign dep_stall = de_valid & (reg_hit | (zf_busy & repne_flag));
  assign hlt_stall = de_valid & is_hlt;
  assign stall_de  = dep_stall | hlt_stall;
  assign ld_ag     = advance;

  // enter the loop on a nonzero count; stay in while the count is nonzero and no match.
  assign repne_in0 = ecx_nz & is_repne & de_valid;
  assign repne_in1 = ecx_nz & ~zf;

  // ECX and ZF are only current once no iteration is in flight.
  assign repne_flag_in = (advance && !dep_stall) ? (repne_flag ? repne_in1 : repne_in0)
                                                 : repne_flag;

  assign repne_stall = repne_flag_in & de_valid;

  assign repne_stop = (is_repne & ~ecx_nz & ~repne_flag) |
                      (repne_flag & (~ecx_nz | zf));

  assign v_ag = de_valid & ~is_hlt & ~dep_stall & ~repne_stop;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      repne_flag <= 1'b0;
    end else begin
      repne_flag <= repne_flag_in;
    end
  end

endmodule

// File: rtl/pipe_stage_track.sv
module pipe_stage_track (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              advance,
  input  logic              v_ag,
  input  pipe_pkg::uop_t    de_uop,
  input  pipe_pkg::retire_t ex_result,
  output pipe_pkg::uop_t    ro_uop,
  output pipe_pkg::uop_t    ex_uop,
  output pipe_pkg::wrec_t   ag_rec,
  output pipe_pkg::wrec_t   ro_rec,
  output pipe_pkg::wrec_t   ex_rec,
  output pipe_pkg::wrec_t   wb_rec,
  output logic              retire_valid,
  output pipe_pkg::retire_t retire
);

  pipe_pkg::uop_t ag_q;
  pipe_pkg::uop_t ro_q;
  pipe_pkg::uop_t ex_q;
  logic           ag_v;
  logic           ro_v;
  logic           ex_v;
  logic           wb_v;
  logic           wb_wr_reg;
  logic           wb_wr_zf;

  function automatic pipe_pkg::wrec_t make_rec(input logic v, input pipe_pkg::uop_t u);
    pipe_pkg::wrec_t r;
    r.valid  = v;
    r.dst    = u.dst;
    r.wr_reg = u.wr_reg;
    r.wr_zf  = u.wr_zf;
    return r;
  endfunction

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ag_v <= 1'b0;
      ro_v <= 1'b0;
      ex_v <= 1'b0;
      wb_v <= 1'b0;
    end else if (advance) begin
      ag_v <= v_ag;
      ro_v <= ag_v;
      ex_v <= ro_v;
      wb_v <= ex_v & (ex_q.wr_reg | ex_q.wr_zf);   // only writers reach the retire port.
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      ag_q      <= de_uop;
      ro_q      <= ag_q;
      ex_q      <= ro_q;
      retire    <= ex_result;
      wb_wr_reg <= ex_q.wr_reg;
      wb_wr_zf  <= ex_q.wr_zf;
    end
  end

  // while frozen the register file is addressed with the ex sources, so the
  // operand registers in ex reload the values they already hold.
  assign ro_uop = advance ? ro_q : ex_q;
  assign ex_uop = ex_q;

  assign ag_rec = make_rec(ag_v, ag_q);
  assign ro_rec = make_rec(ro_v, ro_q);
  assign ex_rec = make_rec(ex_v, ex_q);

  assign wb_rec.valid  = wb_v;
  assign wb_rec.dst    = retire.dst;
  assign wb_rec.wr_reg = wb_wr_reg;
  assign wb_rec.wr_zf  = wb_wr_zf;

  assign retire_valid = wb_v;

endmodule

// File: rtl/reg_file.sv
`include "pipe_config.svh"

module reg_file (
  input  logic              clk,
  input  logic              arst_n,
  input  pipe_pkg::uop_t    ro_uop,
  output pipe_pkg::word_t   rd_a,
  output pipe_pkg::word_t   rd_b,
  input  logic              wb_we,
  input  pipe_pkg::retire_t wb_data,
  output pipe_pkg::word_t   ecx,
  output logic              zf
);

  pipe_pkg::word_t regs [`PIPE_NREGS];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `PIPE_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_we) begin
      regs[wb_data.dst] <= wb_data.data;
    end
  end

  // every retiring operation sets ZF along with its register.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      zf <= 1'b0;
    end else if (wb_we) begin
      zf <= wb_data.zf;
    end
  end

  assign rd_a = regs[ro_uop.dst];   // destination doubles as the first operand.
  assign rd_b = regs[ro_uop.src];

  assign ecx = regs[pipe_pkg::ecx_idx];

endmodule

// File: rtl/exec_unit.sv
module exec_unit (
  input  logic              clk,
  input  logic              arst_n,
  input  pipe_pkg::uop_t    ex_uop,
  input  pipe_pkg::word_t   opnd_a,
  input  pipe_pkg::word_t   opnd_b,
  output pipe_pkg::retire_t ex_result
);

  pipe_pkg::word_t a_q;
  pipe_pkg::word_t b_q;
  pipe_pkg::word_t res;
  logic            zf_new;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      a_q <= '0;
      b_q <= '0;
    end else begin
      a_q <= opnd_a;
      b_q <= opnd_b;
    end
  end

  always_comb begin
    res    = a_q;
    zf_new = 1'b0;
    case (ex_uop.op)
      pipe_pkg::op_add: begin
        res    = a_q + b_q;
        zf_new = res == '0;
      end
      pipe_pkg::op_sub: begin
        res    = a_q - b_q;
        zf_new = res == '0;
      end
      pipe_pkg::op_xor: begin
        res    = a_q ^ b_q;
        zf_new = res == '0;
      end
      pipe_pkg::op_movi: begin
        res    = ex_uop.imm;
        zf_new = res == '0;
      end
      pipe_pkg::op_repne_scan: begin
        res    = a_q - pipe_pkg::word_t'(1);   // a_q holds ECX here.
        zf_new = res[7:0] == ex_uop.imm[7:0];
      end
      default: begin
        zf_new = 1'b0;
      end
    endcase
  end

  always_comb begin
    ex_result.dst      = ex_uop.dst;
    ex_result.data     = res;
    ex_result.zf       = zf_new;
    ex_result.rep_iter = ex_uop.rep_iter;
  end

endmodule

// File: rtl/x86_core_top.sv
module x86_core_top (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              insn_valid,
  output logic              insn_ready,
  input  pipe_pkg::insn_u   insn,
  output logic              retire_valid,
  input  logic              retire_ready,
  output pipe_pkg::retire_t retire,
  output logic              halted
);

  logic              advance;
  logic              wb_we;
  logic              de_valid;
  logic              stall_de;
  logic              repne_stall;
  logic              v_ag;
  logic              ld_ag;
  logic              zf;
  pipe_pkg::uop_t    de_uop;
  pipe_pkg::uop_t    ro_uop;
  pipe_pkg::uop_t    ex_uop;
  pipe_pkg::wrec_t   ag_rec;
  pipe_pkg::wrec_t   ro_rec;
  pipe_pkg::wrec_t   ex_rec;
  pipe_pkg::wrec_t   wb_rec;
  pipe_pkg::word_t   rd_a;
  pipe_pkg::word_t   rd_b;
  pipe_pkg::word_t   ecx;
  pipe_pkg::retire_t ex_result;

  // a retire record waiting on the consumer freezes every stage.
  assign advance = ~retire_valid | retire_ready;
  assign wb_we   = retire_valid & retire_ready;

  de_stage u_de_stage (
    .clk         (clk),
    .arst_n      (arst_n),
    .insn_valid  (insn_valid),
    .insn_ready  (insn_ready),
    .insn        (insn),
    .stall_de    (stall_de),
    .repne_stall (repne_stall),
    .ld_ag       (ld_ag),
    .de_valid    (de_valid),
    .de_uop      (de_uop),
    .halted      (halted)
  );

  de_dep_v_ld_logic u_de_dep (
    .clk         (clk),
    .arst_n      (arst_n),
    .advance     (advance),
    .de_valid    (de_valid),
    .de_uop      (de_uop),
    .ag_rec      (ag_rec),
    .ro_rec      (ro_rec),
    .ex_rec      (ex_rec),
    .wb_rec      (wb_rec),
    .ecx         (ecx),
    .zf          (zf),
    .dep_stall   (),
    .repne_stall (repne_stall),
    .hlt_stall   (),
    .stall_de    (stall_de),
    .v_ag        (v_ag),
    .ld_ag       (ld_ag)
  );

  pipe_stage_track u_stages (
    .clk          (clk),
    .arst_n       (arst_n),
    .advance      (advance),
    .v_ag         (v_ag),
    .de_uop       (de_uop),
    .ex_result    (ex_result),
    .ro_uop       (ro_uop),
    .ex_uop       (ex_uop),
    .ag_rec       (ag_rec),
    .ro_rec       (ro_rec),
    .ex_rec       (ex_rec),
    .wb_rec       (wb_rec),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

  reg_file u_reg_file (
    .clk     (clk),
    .arst_n  (arst_n),
    .ro_uop  (ro_uop),
    .rd_a    (rd_a),
    .rd_b    (rd_b),
    .wb_we   (wb_we),
    .wb_data (retire),
    .ecx     (ecx),
    .zf      (zf)
  );

  exec_unit u_exec (
    .clk       (clk),
    .arst_n    (arst_n),
    .ex_uop    (ex_uop),
    .opnd_a    (rd_a),
    .opnd_b    (rd_b),
    .ex_result (ex_result)
  );

endmodule

// File: verif/tb_x86_core.sv
module tb_x86_core;
  timeunit 1ns;
  timeprecision 1ps;

  logic              clk;
  logic              arst_n;
  logic              insn_valid;
  logic              insn_ready;
  pipe_pkg::insn_u   insn;
  logic              retire_valid;
  logic              retire_ready;
  pipe_pkg::retire_t retire;
  logic              halted;

  pipe_pkg::word_t   mregs [2**pipe_pkg::reg_aw];   // model of the architectural registers.
  logic              mzf;
  pipe_pkg::retire_t exp_q [$];
  pipe_pkg::insn_u   prog [$];
  pipe_pkg::retire_t want;
  pipe_pkg::retire_t held_rec;
  logic              stall_seen;
  logic              bp_on;
  int                errors;
  int                checks;
  int                err_base;
  int                rep_seen;
  int                exp_total;
  int                cycle_cnt;

  x86_core_top i_dut (
    .clk          (clk),
    .arst_n       (arst_n),
    .insn_valid   (insn_valid),
    .insn_ready   (insn_ready),
    .insn         (insn),
    .retire_valid (retire_valid),
    .retire_ready (retire_ready),
    .retire       (retire),
    .halted       (halted)
  );

  always #5 clk = ~clk;

  function automatic pipe_pkg::insn_u alu_word(input pipe_pkg::op_e op, input int dst,
                                               input int src, input int imm);
    pipe_pkg::insn_u w;
    w         = '0;
    w.alu.op  = op;
    w.alu.dst = pipe_pkg::reg_idx_t'(dst);
    w.alu.src = pipe_pkg::reg_idx_t'(src);
    w.alu.imm = 15'(imm);
    return w;
  endfunction

  function automatic pipe_pkg::insn_u scan_word(input logic [7:0] cmp);
    pipe_pkg::insn_u w;
    w          = '0;
    w.ctrl.op  = pipe_pkg::op_repne_scan;
    w.ctrl.cmp = cmp;
    return w;
  endfunction

  // ALU ops combine dst with src and a scan step counts ECX down by one.
  function automatic pipe_pkg::retire_t ref_retire(input pipe_pkg::insn_u w);
    pipe_pkg::retire_t r;
    pipe_pkg::word_t   a;
    pipe_pkg::word_t   b;
    pipe_pkg::word_t   res;
    a = mregs[w.alu.dst];
    b = mregs[w.alu.src];
    r = '0;
    case (w.alu.op)
      pipe_pkg::op_add:  res = a + b;
      pipe_pkg::op_sub:  res = a - b;
      pipe_pkg::op_xor:  res = a ^ b;
      pipe_pkg::op_movi: res = {17'd0, w.alu.imm};
      default:           res = mregs[1] - 32'd1;
    endcase
    if (w.alu.op == pipe_pkg::op_repne_scan) begin
      r.dst      = 3'd1;
      r.zf       = res[7:0] == w.ctrl.cmp;
      r.rep_iter = 1'b1;
    end else begin
      r.dst = w.alu.dst;
      r.zf  = res == 32'd0;
    end
    r.data       = res;
    mregs[r.dst] = res;
    mzf          = r.zf;
    return r;
  endfunction

  function automatic void expect_insn(input pipe_pkg::insn_u w);
    if (w.alu.op == pipe_pkg::op_repne_scan) begin
      if (mregs[1] != 32'd0) begin
        do begin
          exp_q.push_back(ref_retire(w));
          exp_total++;
        end while (mregs[1] != 32'd0 && !mzf);
      end
    end else if (w.alu.op == pipe_pkg::op_add || w.alu.op == pipe_pkg::op_sub ||
                 w.alu.op == pipe_pkg::op_xor || w.alu.op == pipe_pkg::op_movi) begin
      exp_q.push_back(ref_retire(w));
      exp_total++;
    end
  endfunction

  // called just after a rising edge; returns on the edge where the DUT took the word.
  task automatic send_insn(input pipe_pkg::insn_u w);
    expect_insn(w);
    insn_valid <= 1'b1;
    insn       <= w;
    @(posedge clk);
    while (!insn_ready) @(posedge clk);
  endtask

  task automatic wait_drain();
    insn_valid <= 1'b0;
    while (exp_q.size() != 0) @(posedge clk);
    repeat (3) @(posedge clk);
  endtask

  task automatic begin_test();
    err_base = errors;
  endtask

  task automatic end_test(input string name);
    $display("test %s: %s, %0d errors", name, (errors == err_base) ? "pass" : "FAIL",
             errors - err_base);
  endtask

  task automatic run_scan(input int ecx_init, input logic [7:0] cmp, input int iters);
    int base;
    base = rep_seen;
    send_insn(alu_word(pipe_pkg::op_movi, 1, 0, ecx_init));
    send_insn(scan_word(cmp));
    send_insn(alu_word(pipe_pkg::op_add, 0, 1, 0));   // reads ECX after the loop.
    wait_drain();
    checks++;
    if (rep_seen - base != iters) begin
      errors++;
      $display("mismatch at %0t: scan from ECX %0d ran %0d iterations where %0d were due",
               $time, ecx_init, rep_seen - base, iters);
    end
  endtask

  task automatic build_mix(input int n);
    int sel;
    for (int i = 0; i < n; i++) begin
      sel = $urandom % 8;
      if (sel == 0) begin
        prog.push_back(alu_word(pipe_pkg::op_movi, 1, 0, $urandom % 6));
        prog.push_back(scan_word(8'($urandom % 4)));
      end else if (sel < 3) begin
        prog.push_back(alu_word(pipe_pkg::op_movi, $urandom % 8, 0, $urandom));
      end else if (sel < 5) begin
        prog.push_back(alu_word(pipe_pkg::op_add, $urandom % 8, $urandom % 8, 0));
      end else if (sel < 7) begin
        prog.push_back(alu_word(pipe_pkg::op_sub, $urandom % 8, $urandom % 8, 0));
      end else begin
        prog.push_back(alu_word(pipe_pkg::op_xor, $urandom % 8, $urandom % 8, 0));
      end
    end
  endtask

  always @(posedge clk) begin
    retire_ready <= bp_on ? ($urandom % 3 != 0) : 1'b1;
  end

  // compares every retire transfer against the head of the expected queue.
  always @(posedge clk) begin
    if (arst_n) begin
      if (stall_seen) begin
        checks++;
        if (!retire_valid || retire !== held_rec) begin
          errors++;
          $display("retire record changed at %0t before it was taken", $time);
        end
      end
      stall_seen = retire_valid && !retire_ready;
      held_rec   = retire;
      if (retire_valid && retire_ready) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("a record retired at %0t with nothing expected, dst %0d data %h",
                   $time, retire.dst, retire.data);
        end else begin
          want = exp_q.pop_front();
          checks++;
          if (retire !== want) begin
            errors++;
            $display("mismatch at %0t: got dst %0d data %h zf %b rep %b, want %0d %h %b %b",
                     $time, retire.dst, retire.data, retire.zf, retire.rep_iter,
                     want.dst, want.data, want.zf, want.rep_iter);
          end
          if (retire.rep_iter) begin
            rep_seen++;
          end
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > 40 * exp_total + 200) begin
      $display("timeout after %0d cycles with %0d records still due", cycle_cnt, exp_q.size());
      $display("Checks failed");
      $finish;
    end
  end

  initial begin
    clk          = 1'b0;
    arst_n       = 1'b0;
    insn_valid   = 1'b0;
    insn         = '0;
    retire_ready = 1'b1;
    bp_on        = 1'b0;
    stall_seen   = 1'b0;
    mzf          = 1'b0;
    errors       = 0;
    checks       = 0;
    rep_seen     = 0;
    exp_total    = 0;
    cycle_cnt    = 0;
    for (int i = 0; i < 2**pipe_pkg::reg_aw; i++) begin
      mregs[i] = '0;
    end
    void'($urandom(32'hb531_5056));
    repeat (10) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);
    checks++;
    if (insn_ready || retire_valid || halted) begin
      errors++;
      $display("mismatch at %0t: outputs not idle in the first cycle after reset", $time);
    end

    begin_test();
    for (int r = 0; r < 8; r++) begin
      send_insn(alu_word(pipe_pkg::op_movi, r, 0, (r == 6) ? 0 : 1000 * r + 7));
    end
    send_insn(alu_word(pipe_pkg::op_add, 0, 1, 0));
    send_insn(alu_word(pipe_pkg::op_sub, 2, 3, 0));
    send_insn(alu_word(pipe_pkg::op_xor, 4, 4, 0));   // clears r4 and sets ZF.
    send_insn(alu_word(pipe_pkg::op_add, 5, 6, 0));
    wait_drain();
    end_test("independent_alu");

    begin_test();
    for (int d = 1; d <= 4; d++) begin
      send_insn(alu_word(pipe_pkg::op_movi, 2, 0, 100 * d + 3));
      for (int k = 1; k < d; k++) begin
        send_insn(alu_word(pipe_pkg::op_movi, 3 + k, 0, k));
      end
      send_insn(alu_word(pipe_pkg::op_add, 3, 2, 0));
      wait_drain();   // only the r2 writer is in flight when the add reaches decode.
    end
    send_insn(alu_word(pipe_pkg::op_movi, 0, 0, 1));
    send_insn(alu_word(pipe_pkg::op_add, 0, 0, 0));
    send_insn(alu_word(pipe_pkg::op_add, 0, 0, 0));
    send_insn(alu_word(pipe_pkg::op_xor, 0, 3, 0));
    send_insn(alu_word(pipe_pkg::op_sub, 0, 0, 0));
    wait_drain();
    end_test("dependent_alu");

    begin_test();
    run_scan(5, 8'haa, 5);
    run_scan(10, 8'h06, 4);
    run_scan(0, 8'h03, 0);
    end_test("repne_scan");

    begin_test();
    build_mix(40);
    @(posedge clk);
    bp_on <= 1'b1;
    while (prog.size() != 0) begin
      send_insn(prog.pop_front());
    end
    wait_drain();
    bp_on <= 1'b0;
    repeat (2) @(posedge clk);
    end_test("random_backpressure");

    begin_test();
    send_insn(alu_word(pipe_pkg::op_movi, 7, 0, 16'h1234));
    send_insn(alu_word(pipe_pkg::op_hlt, 0, 0, 0));
    insn_valid <= 1'b1;
    insn       <= alu_word(pipe_pkg::op_movi, 0, 0, 16'h55);   // must never be taken.
    while (!halted) @(posedge clk);
    repeat (20) begin
      @(posedge clk);
      checks++;
      if (insn_ready || !halted) begin
        errors++;
        $display("mismatch at %0t: decode accepted input or dropped halted after HLT", $time);
      end
    end
    wait_drain();
    repeat (10) @(posedge clk);
    end_test("halt");

    checks++;
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d expected records never retired", exp_q.size());
    end
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: build.f
+incdir+rtl
rtl/pipe_pkg.sv
rtl/de_stage.sv
rtl/de_dep_v_ld_logic.sv
rtl/pipe_stage_track.sv
rtl/reg_file.sv
rtl/exec_unit.sv
rtl/x86_core_top.sv
verif/tb_x86_core.sv

// File: Bender.yml
package:
  name: x86_core_pipe

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/pipe_pkg.sv
      - rtl/de_stage.sv
      - rtl/de_dep_v_ld_logic.sv
      - rtl/pipe_stage_track.sv
      - rtl/reg_file.sv
      - rtl/exec_unit.sv
      - rtl/x86_core_top.sv
  - target: test
    files:
      - verif/tb_x86_core.sv
